//--- rtl/ioPkg.sv
// ==============================
// I/O port ready state and the write flag carried by the pipeline
// ==============================
`default_nettype none

package ioPkg;

    // Ready state of a single-entry write port
    typedef enum logic {
        EMPTY = 1'b0,
        FULL  = 1'b1
    } portState_t;

    // Write flag that rides beside the instruction through the ALU
    typedef struct packed {
        logic isIo;
        // Reserved copy of the thread ready level
        logic ready;
    } portWrite_t;

endpackage

`default_nettype wire

//--- rtl/memPkg.sv
// ==============================
// Datapath word, address widths and RAM write types
// ==============================
`default_nettype none

package memPkg;

    localparam int wordWidth = 36;
    localparam int addrWidth = 10;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [addrWidth-1:0] addr_t;

    typedef struct packed {
        logic  wren;
        addr_t addr;
        word_t data;
    } ramWrite_t;

    // What the ALU stage hands back to the write path
    typedef struct packed {
        logic  wren;
        addr_t addr;
        word_t result;
    } aluOut_t;

endpackage

`default_nettype wire

//--- rtl/pipeDelay.sv
// ==============================
// Fixed-depth register delay line
// ==============================
`timescale 1ns/100ps
`default_nettype none

module pipeDelay #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  wire logic     clock,
    input  wire logic     reset,
    input  wire payload_t in,
    output payload_t      out
);

    payload_t stages [depth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            // Shift everything one stage further down the line
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[depth-1];

endmodule

`default_nettype wire

//--- rtl/ioCheck.sv
// ==============================
// Port window decode and masked empty/full select
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioCheck #(
    parameter int portCount     = 4,
    parameter int portBaseAddr  = 'h3F0,
    parameter int portAddrWidth = 2
) (
    input  wire logic                 clock,
    input  wire memPkg::addr_t        addr,
    input  wire logic [portCount-1:0] emptyFull,
    output logic                      emptyFullMasked,
    output logic                      addrIsIoReg
);

    localparam memPkg::addr_t baseAddr = memPkg::addr_t'(portBaseAddr);
    localparam int topBit = memPkg::addrWidth - 1;

    logic                     addrIsIo;
    logic [portAddrWidth-1:0] portSel;
    logic [portAddrWidth-1:0] portSelReg;
    ioPkg::portState_t        selState;

    // Upper bits pick the window, low bits pick the port inside it
    assign portSel  = addr[portAddrWidth-1:0];
    assign addrIsIo = (addr[topBit:portAddrWidth] == baseAddr[topBit:portAddrWidth])
                      && (portSel < portCount);

    always_ff @(posedge clock) begin
        addrIsIoReg <= addrIsIo;
        portSelReg  <= portSel;
    end

    assign selState = ioPkg::portState_t'(emptyFull[portSelReg]);

    // Only a port address can stall, and only when its buffer is not ready
    assign emptyFullMasked = addrIsIoReg && (selState != ioPkg::EMPTY);

endmodule

`default_nettype wire

//--- rtl/ioActive.sv
// ==============================
// Registered one-hot port enable
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioActive #(
    parameter int portCount     = 4,
    parameter int portBaseAddr  = 'h3F0,
    parameter int portAddrWidth = 2
) (
    input  wire logic          clock,
    input  wire logic          reset,
    input  wire logic          enable,
    input  wire memPkg::addr_t addr,
    output logic [portCount-1:0] active
);

    localparam memPkg::addr_t baseAddr = memPkg::addr_t'(portBaseAddr);
    localparam int topBit = memPkg::addrWidth - 1;

    logic [portAddrWidth-1:0] portSel;
    logic                     hit;

    assign portSel = addr[portAddrWidth-1:0];
    assign hit     = enable
                     && (addr[topBit:portAddrWidth] == baseAddr[topBit:portAddrWidth])
                     && (portSel < portCount);

    always_ff @(posedge clock) begin
        if (reset) begin
            active <= '0;
        end else begin
            for (int i = 0; i < portCount; i++) begin
                active[i] <= hit && (portSel == portAddrWidth'(i));
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ioWrite.sv
// ==============================
// Write-is-I/O flag, RAM write register and per-port data copies
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioWrite #(
    parameter int portCount     = 4,
    parameter int portBaseAddr  = 'h3F0,
    parameter int portAddrWidth = 2
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire memPkg::addr_t        addrRaw,
    input  wire logic [portCount-1:0] emptyFull,
    input  wire logic                 ioReady,
    input  wire memPkg::word_t        aluResult,
    input  wire memPkg::addr_t        aluAddr,
    input  wire logic                 aluWriteIsIo,
    input  wire logic                 aluWren,
    output logic                      writeIsIo,
    output logic                      emptyFullMasked,
    output logic [portCount-1:0]      activeIo,
    output memPkg::word_t [portCount-1:0] dataIo,
    output memPkg::ramWrite_t         ramWrite
);

    logic addrIsIoReg;
    logic writeIsIoMid;

    ioCheck #(
        .portCount     (portCount),
        .portBaseAddr  (portBaseAddr),
        .portAddrWidth (portAddrWidth)
    ) check (
        .clock           (clock),
        .addr            (addrRaw),
        .emptyFull       (emptyFull),
        .emptyFullMasked (emptyFullMasked),
        .addrIsIoReg     (addrIsIoReg)
    );

    // Two stages bring the flag level with the instruction at the ALU entrance
    always_ff @(posedge clock) begin
        if (reset) begin
            writeIsIoMid <= 1'b0;
            writeIsIo    <= 1'b0;
            ramWrite.wren <= 1'b0;
        end else begin
            writeIsIoMid <= addrIsIoReg & ioReady;
            writeIsIo    <= writeIsIoMid;
            ramWrite.wren <= aluWren;
        end
    end

    always_ff @(posedge clock) begin
        ramWrite.addr <= aluAddr;
        ramWrite.data <= aluResult;
    end

    // A separate register per port keeps the fanout to each buffer local
    always_ff @(posedge clock) begin
        for (int i = 0; i < portCount; i++) begin
            dataIo[i] <= aluResult;
        end
    end

    ioActive #(
        .portCount     (portCount),
        .portBaseAddr  (portBaseAddr),
        .portAddrWidth (portAddrWidth)
    ) activate (
        .clock  (clock),
        .reset  (reset),
        .enable (aluWriteIsIo & aluWren),
        .addr   (aluAddr),
        .active (activeIo)
    );

endmodule

`default_nettype wire

//--- rtl/writePortBank.sv
// ==============================
// Single-entry output buffers with full flags
// ==============================
`timescale 1ns/100ps
`default_nettype none

module writePortBank #(
    parameter int portCount = 4
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic [portCount-1:0] active,
    input  wire memPkg::word_t [portCount-1:0] data,
    input  wire logic [portCount-1:0] drain,
    output memPkg::word_t [portCount-1:0] portData,
    output logic [portCount-1:0]      portFull
);

    ioPkg::portState_t state [portCount];

    for (genvar i = 0; i < portCount; i++) begin : gPort

        // A write in the same cycle as a drain leaves the port full
        always_ff @(posedge clock) begin
            if (reset) begin
                state[i] <= ioPkg::EMPTY;
            end else if (active[i]) begin
                state[i] <= ioPkg::FULL;
            end else if (drain[i]) begin
                state[i] <= ioPkg::EMPTY;
            end
        end

        always_ff @(posedge clock) begin
            if (active[i]) begin
                portData[i] <= data[i];
            end
        end

        assign portFull[i] = (state[i] == ioPkg::FULL);

    end

endmodule

`default_nettype wire

//--- rtl/ioWriteTop.sv
// ==============================
// I/O write path with ALU stand-in and port bank
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioWriteTop #(
    parameter int portCount     = 4,
    parameter int portBaseAddr  = 'h3F0,
    parameter int portAddrWidth = 2,
    parameter int aluDepth      = 3
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire memPkg::addr_t        rawAddr,
    input  wire logic                 ioReady,
    input  wire memPkg::aluOut_t      aluIn,
    input  wire logic [portCount-1:0] drain,
    output logic                      ioStall,
    output logic                      writeIsIo,
    output memPkg::ramWrite_t         ramWrite,
    output memPkg::word_t [portCount-1:0] portData,
    output logic [portCount-1:0]      portFull
);

    ioPkg::portWrite_t             flagIn;
    ioPkg::portWrite_t             flagOut;
    memPkg::aluOut_t               aluOut;
    logic [portCount-1:0]          activeIo;
    memPkg::word_t [portCount-1:0] dataIo;

    assign flagIn = '{isIo: writeIsIo, ready: ioReady};

    ioWrite #(
        .portCount     (portCount),
        .portBaseAddr  (portBaseAddr),
        .portAddrWidth (portAddrWidth)
    ) write (
        .clock           (clock),
        .reset           (reset),
        .addrRaw         (rawAddr),
        .emptyFull       (portFull),
        .ioReady         (ioReady),
        .aluResult       (aluOut.result),
        .aluAddr         (aluOut.addr),
        .aluWriteIsIo    (flagOut.isIo),
        .aluWren         (aluOut.wren),
        .writeIsIo       (writeIsIo),
        .emptyFullMasked (ioStall),
        .activeIo        (activeIo),
        .dataIo          (dataIo),
        .ramWrite        (ramWrite)
    );

    // Flag and operands take the same path length through the ALU
    pipeDelay #(.depth(aluDepth), .payload_t(ioPkg::portWrite_t)) flagDelay (
        .clock (clock),
        .reset (reset),
        .in    (flagIn),
        .out   (flagOut)
    );

    pipeDelay #(.depth(aluDepth), .payload_t(memPkg::aluOut_t)) aluDelay (
        .clock (clock),
        .reset (reset),
        .in    (aluIn),
        .out   (aluOut)
    );

    writePortBank #(.portCount(portCount)) bank (
        .clock    (clock),
        .reset    (reset),
        .active   (activeIo),
        .data     (dataIo),
        .drain    (drain),
        .portData (portData),
        .portFull (portFull)
    );

endmodule

`default_nettype wire

//--- tests/ioWrite_assert.sv
// ==============================
// Concurrent assertions on the port enables and full flags
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioWriteProps #(
    parameter int portCount = 4
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic [portCount-1:0] activeIo,
    input  wire memPkg::aluOut_t      aluOut,
    input  wire logic [portCount-1:0] drain,
    input  wire logic [portCount-1:0] portFull
);

    oneHotEnable: assert property (@(posedge clock) disable iff (reset) $onehot0(activeIo))
        else $error("activeIo has more than one port enabled");

    // No write request means no enable one cycle later
    noWrenNoEnable: assert property (@(posedge clock) disable iff (reset)
        !aluOut.wren |=> (activeIo == '0))
        else $error("activeIo set after a cycle without wren");

    for (genvar i = 0; i < portCount; i++) begin : gDrain
        drainEmpties: assert property (@(posedge clock) disable iff (reset)
            (drain[i] && !activeIo[i]) |=> !portFull[i])
            else $error("port %0d still full after a drain without a write", i);
    end

endmodule

bind ioWriteTop ioWriteProps #(.portCount(portCount)) props0 (
    .clock    (clock),
    .reset    (reset),
    .activeIo (activeIo),
    .aluOut   (aluOut),
    .drain    (drain),
    .portFull (portFull)
);

`default_nettype wire

//--- tests/ioWriteTb.sv
// ==============================
// Testbench for the I/O write path with random stimulus, cycle model and checks
// ==============================
`timescale 1ns/100ps
`default_nettype none

module ioWriteTb;

    localparam int portCount = 4;
    localparam int aluDepth = 3;
    localparam memPkg::addr_t portBase = 10'h3F0;
    localparam int runLength = 300;
    localparam int collideLength = 100;
    localparam int timeoutLimit = 2 * (4 * runLength + collideLength) + 100;

    logic clock;
    logic reset;
    memPkg::addr_t rawAddr;
    logic ioReady;
    memPkg::aluOut_t aluIn;
    logic [portCount-1:0] drain;
    logic ioStall;
    logic writeIsIo;
    memPkg::ramWrite_t ramWrite;
    memPkg::word_t [portCount-1:0] portData;
    logic [portCount-1:0] portFull;

    // One model variable per pipeline stage of the write path
    logic mAddrIsIoReg, mMid, mWriteIsIo;
    int mSel;
    logic mFlagQ[$];
    memPkg::aluOut_t mAluQ[$];
    memPkg::ramWrite_t mRamWrite;
    logic [portCount-1:0] mActive, mFull, mValid;
    memPkg::word_t mDataIo;
    memPkg::word_t mData[portCount];

    logic [31:0] seed = 32'd23;
    int winPct, readyPct, wrenPct, drainPct;
    logic drainFollow;
    int testErrors, failedTests, testsRun, checkCount, collisions, cycleCount;

    ioWriteTop dut0 (
        .clock (clock), .reset (reset), .rawAddr (rawAddr), .ioReady (ioReady),
        .aluIn (aluIn), .drain (drain), .ioStall (ioStall), .writeIsIo (writeIsIo),
        .ramWrite (ramWrite), .portData (portData), .portFull (portFull)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic rollPercent(int pct);
        return ((lcgNext() >> 16) % 100) < pct;
    endfunction

    function automatic memPkg::word_t randWord();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi[31:28], lo[31:16], hi[27:12]};
    endfunction

    // Half-open window of portCount addresses starting at the base
    function automatic logic inWindow(memPkg::addr_t a);
        return (int'(a) >= int'(portBase)) && (int'(a) < int'(portBase) + portCount);
    endfunction

    function automatic memPkg::addr_t randAddr(int pct);
        if (rollPercent(pct)) begin
            return memPkg::addr_t'(int'(portBase) + int'((lcgNext() >> 16) % portCount));
        end
        return memPkg::addr_t'(lcgNext() >> 16);
    endfunction

    task automatic logFail(string msg);
        testErrors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic advanceModel();
        memPkg::aluOut_t aluFront;
        logic flagFront;
        aluFront = mAluQ.pop_front();
        flagFront = mFlagQ.pop_front();
        // A write beats a drain on the same port
        for (int i = 0; i < portCount; i++) begin
            if (mActive[i] && drain[i]) collisions++;
            if (mActive[i]) begin
                mFull[i] = 1'b1;
                mData[i] = mDataIo;
                mValid[i] = 1'b1;
            end else if (drain[i]) begin
                mFull[i] = 1'b0;
            end
        end
        mActive = '0;
        if (flagFront && aluFront.wren && inWindow(aluFront.addr)) begin
            mActive[int'(aluFront.addr) - int'(portBase)] = 1'b1;
        end
        mDataIo = aluFront.result;
        mRamWrite = '{wren: aluFront.wren, addr: aluFront.addr, data: aluFront.result};
        mAluQ.push_back(aluIn);
        mFlagQ.push_back(mWriteIsIo);
        mWriteIsIo = mMid;
        mMid = mAddrIsIoReg & ioReady;
        mAddrIsIoReg = inWindow(rawAddr);
        mSel = int'(rawAddr) - int'(portBase);
    endtask

    task automatic driveInputs();
        memPkg::aluOut_t nextAlu;
        logic [portCount-1:0] nextDrain;
        nextAlu.wren = rollPercent(wrenPct);
        nextAlu.addr = randAddr(winPct);
        nextAlu.result = randWord();
        for (int i = 0; i < portCount; i++) begin
            nextDrain[i] = rollPercent(drainPct);
        end
        // Line the drain up with the enable the model expects this cycle
        if (drainFollow) nextDrain = nextDrain | mActive;
        rawAddr <= randAddr(winPct);
        ioReady <= rollPercent(readyPct);
        aluIn <= nextAlu;
        drain <= nextDrain;
    endtask

    task automatic checkOutputs();
        logic expStall;
        expStall = mAddrIsIoReg ? mFull[mSel] : 1'b0;
        checkCount++;
        if (writeIsIo !== mWriteIsIo) logFail($sformatf("writeIsIo %b, expected %b",
            writeIsIo, mWriteIsIo));
        if (ramWrite !== mRamWrite) logFail($sformatf("ramWrite %h, expected %h",
            ramWrite, mRamWrite));
        if (dut0.activeIo !== mActive) logFail($sformatf("activeIo %b, expected %b",
            dut0.activeIo, mActive));
        if (ioStall !== expStall) logFail($sformatf("ioStall %b, expected %b",
            ioStall, expStall));
        if (portFull !== mFull) logFail($sformatf("portFull %b, expected %b",
            portFull, mFull));
        for (int i = 0; i < portCount; i++) begin
            if (mValid[i] && portData[i] !== mData[i]) logFail($sformatf(
                "portData[%0d] %h, expected %h", i, portData[i], mData[i]));
        end
    endtask

    task automatic runTest(int cycles, int win, int ready, int wren, int drn);
        winPct = win;
        readyPct = ready;
        wrenPct = wren;
        drainPct = drn;
        testErrors = 0;
        repeat (cycles) begin
            @(posedge clock);
            advanceModel();
            driveInputs();
            @(negedge clock);
            checkOutputs();
        end
    endtask

    task automatic closeTest(string name);
        testsRun++;
        if (testErrors != 0) failedTests++;
        $display("Test %0d %s: %0d errors", testsRun, name, testErrors);
    endtask

    initial begin
        reset = 1'b1;
        rawAddr = '0;
        ioReady = 1'b0;
        aluIn = '0;
        drain = '0;
        drainFollow = 1'b0;
        {mAddrIsIoReg, mMid, mWriteIsIo, mActive, mFull, mValid} = '0;
        {mSel, failedTests, testsRun, checkCount, collisions, cycleCount} = '0;
        mRamWrite = '0;
        mDataIo = '0;
        for (int i = 0; i < aluDepth; i++) begin
            mAluQ.push_back('0);
            mFlagQ.push_back(1'b0);
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        testErrors = 0;
        if (writeIsIo !== 1'b0 || ramWrite.wren !== 1'b0) logFail("flags not clear after reset");
        if (dut0.activeIo !== '0 || portFull !== '0) logFail("ports not clear after reset");
        closeTest("reset state");
        runTest(runLength, 50, 50, 50, 20);
        closeTest("write-is-I/O flag");
        runTest(runLength, 20, 50, 50, 20);
        closeTest("RAM write");
        runTest(runLength, 50, 70, 70, 10);
        closeTest("port load");
        runTest(runLength, 80, 60, 60, 30);
        closeTest("stall flag");
        drainFollow = 1'b1;
        collisions = 0;
        runTest(collideLength, 100, 100, 100, 0);
        if (collisions == 0) logFail("no write met a drain on the same port");
        closeTest("write against drain");
        $display("Summary: %0d tests, %0d failed, %0d cycle checks",
            testsRun, failedTests, checkCount);
        if (failedTests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/ioPkg.sv
rtl/memPkg.sv
rtl/pipeDelay.sv
rtl/ioCheck.sv
rtl/ioActive.sv
rtl/ioWrite.sv
rtl/writePortBank.sv
rtl/ioWriteTop.sv
tests/ioWrite_assert.sv
tests/ioWriteTb.sv
